/* daq_word_pkg.sv */
package daq_word_pkg;

	localparam int WORD_BITS = 32;	// Width of one sample word on every bus.
	localparam int TAG_BITS = 8;	// Top byte of a marker word.
	localparam int MARKER_CNT_BITS = WORD_BITS - TAG_BITS;
	localparam int MAX_LEN_BITS = 16;	// Widest packet length that is counted.

	typedef logic [WORD_BITS-1:0] word_t;

	// Word count of one packet. The length channel carries a slice of it.
	typedef logic [MAX_LEN_BITS-1:0] pkt_len_t;

	localparam logic [TAG_BITS-1:0] MARKER_TAG = 8'hFE;	// Marks a drop count word.

	// A drop marker has the tag in the top byte and the count below it.
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [MARKER_CNT_BITS-1:0] count;
	} marker_t;

	// Builds the one-word marker packet for a given drop count.
	function automatic word_t make_marker(input logic [MARKER_CNT_BITS-1:0] count);
		marker_t m;
		m.tag = MARKER_TAG;
		m.count = count;
		return word_t'(m);
	endfunction

endpackage

/* daq_ctrl_pkg.sv */
package daq_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,	// Waiting for a request or sending a marker.
		GRANTED,	// A source owns the ring.
		DRAIN_END	// Commit and length push of the finished packet.
	} ctrl_state_t;

	typedef logic [23:0] drop_cnt_t;	// Packets undone since the last marker.

	localparam drop_cnt_t DROP_CNT_MAX = '1;	// The counter sticks here.

	// Index width for n sources. One source still needs a one-bit index.
	function automatic int idx_bits(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* source_select.sv */
`timescale 1ns/1ps

module source_select import daq_word_pkg::*, daq_ctrl_pkg::*; #(
	parameter int NSRC = 4,
	localparam int IDX_BITS = idx_bits(NSRC)
) (
	input logic clk,
	input logic reset,

	input logic [NSRC-1:0] src_req,
	input logic [NSRC-1:0] src_valid,
	input logic [NSRC-1:0] src_end,
	input word_t [NSRC-1:0] src_data,
	output logic [NSRC-1:0] src_grant,

	input logic take,
	output logic pick_valid,
	output logic [IDX_BITS-1:0] pick_idx,

	output logic sel_valid,
	output logic sel_end,
	output word_t sel_data
);

	logic [IDX_BITS-1:0] sel_idx;	// Source that owns the current packet.
	logic active;	// High from the take until the source ends its packet.

	assign pick_valid = |src_req;

	// Fixed priority, so the scan from the top leaves the lowest request.
	always_comb begin
		pick_idx = '0;
		for (int i = NSRC - 1; i >= 0; i--) begin
			if (src_req[i])
				pick_idx = IDX_BITS'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_idx <= '0;
			active <= 1'b0;
			src_grant <= '0;
		end else begin
			src_grant <= '0;	// The grant is a single-cycle pulse.
			if (take) begin
				sel_idx <= pick_idx;
				active <= 1'b1;
				src_grant[pick_idx] <= 1'b1;
			end else if (sel_end) begin
				active <= 1'b0;
			end
		end
	end

	// Steering runs off the latched index, so a word reaches the controller in its own cycle.
	assign sel_valid = active & src_valid[sel_idx];
	assign sel_end = active & src_end[sel_idx];
	assign sel_data = src_data[sel_idx];

endmodule

/* packet_ring.sv */
`timescale 1ns/1ps

module packet_ring import daq_word_pkg::*; #(
	parameter int RING_DEPTH = 1024,
	localparam int AW = $clog2(RING_DEPTH)
) (
	input logic clk,
	input logic reset,

	// Write side, driven by the controller.
	input logic wr_en,
	input word_t wr_data,
	input logic commit,
	input logic revert,
	output logic ring_full,

	// Read side, committed words only.
	output logic out_valid,
	output word_t out_data,
	input logic out_ready
);

	word_t mem [RING_DEPTH];

	// Pointers carry one extra bit so that full and empty differ.
	logic [AW:0] wr_ptr;	// Next free slot, runs ahead inside a packet.
	logic [AW:0] cmt_ptr;	// End of the last committed packet.
	logic [AW:0] rd_ptr;	// Next word to move into the output register.

	logic [AW:0] cmt_next;
	logic [AW:0] used;
	logic load;

	// Slots still held by the writer, committed or not.
	assign used = wr_ptr - rd_ptr;
	assign ring_full = (used == (AW + 1)'(RING_DEPTH));

	// A commit in this cycle already frees its words for the reader.
	assign cmt_next = commit ? wr_ptr : cmt_ptr;

	// The output register takes a word when it is empty or being emptied.
	assign load = (rd_ptr != cmt_next) && (!out_valid || out_ready);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			cmt_ptr <= '0;
		end else begin
			if (revert)
				wr_ptr <= cmt_ptr;	// Drops every word since the last commit.
			else if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (commit)
				cmt_ptr <= wr_ptr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			out_valid <= 1'b0;
		end else if (load) begin
			rd_ptr <= rd_ptr + 1'b1;
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;	// Word taken and nothing committed behind it.
		end
	end

	// Data only moves together with valid, so it holds while the reader stalls.
	always_ff @(posedge clk) begin
		if (load)
			out_data <= mem[rd_ptr[AW-1:0]];
	end

endmodule

/* len_fifo.sv */
`timescale 1ns/1ps

module len_fifo #(
	parameter int LEN_BITS = 12,
	parameter int LEN_DEPTH = 64,
	localparam int AW = (LEN_DEPTH > 1) ? $clog2(LEN_DEPTH) : 1
) (
	input logic clk,
	input logic reset,

	input logic len_push,
	input logic [LEN_BITS-1:0] len_in,
	output logic len_full,

	output logic len_valid,
	output logic [LEN_BITS-1:0] len_data,
	input logic len_ready
);

	logic [LEN_BITS-1:0] mem [LEN_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;	// Entries held, zero to LEN_DEPTH.
	logic push;
	logic pop;

	// Pointers wrap at the depth, which need not be a power of two.
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(LEN_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign len_full = (count == (AW + 1)'(LEN_DEPTH));
	assign len_valid = (count != '0);
	assign len_data = mem[rd_ptr];	// Head entry is shown before it is read.

	assign push = len_push && !len_full;
	assign pop = len_valid && len_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= len_in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* daq_collect_ctrl.sv */
`timescale 1ns/1ps

module daq_collect_ctrl import daq_word_pkg::*, daq_ctrl_pkg::*; #(
	parameter int NSRC = 4,
	parameter int LEN_BITS = 12,
	localparam int IDX_BITS = idx_bits(NSRC)
) (
	input logic clk,
	input logic reset,

	// Source selection.
	input logic pick_valid,
	input logic [IDX_BITS-1:0] pick_idx,
	output logic take,
	input logic sel_valid,
	input logic sel_end,
	input word_t sel_data,

	// Packet ring.
	output logic wr_en,
	output word_t wr_data,
	output logic commit,
	output logic revert,
	input logic ring_full,

	// Length FIFO.
	output logic len_push,
	output logic [LEN_BITS-1:0] len_in,
	input logic len_full
);

	ctrl_state_t state;
	pkt_len_t word_cnt;	// Words written for the open packet.
	logic discard;	// Rest of the packet is thrown away after an overflow.
	drop_cnt_t drop_cnt;
	drop_cnt_t drop_inc;
	logic marker_pending;
	logic marker_room;

	assign marker_pending = (drop_cnt != '0);
	assign marker_room = !ring_full && !len_full;	// One ring word and one length entry.
	assign drop_inc = (drop_cnt == DROP_CNT_MAX) ? drop_cnt : drop_cnt + 1'b1;

	assign len_in = LEN_BITS'(word_cnt);

	always_comb begin
		take = 1'b0;
		wr_en = 1'b0;
		wr_data = sel_data;
		commit = 1'b0;
		revert = 1'b0;
		len_push = 1'b0;
		case (state)
			IDLE: begin
				if (marker_pending) begin
					if (marker_room) begin
						wr_en = 1'b1;
						wr_data = make_marker(drop_cnt);
					end
				end else begin
					take = pick_valid;	// Requests wait until the marker is out.
				end
			end
			GRANTED: begin
				if (sel_valid && !discard) begin
					if (ring_full)
						revert = 1'b1;	// Undo the packet written so far.
					else
						wr_en = 1'b1;
				end
			end
			DRAIN_END: begin
				if (len_full) begin
					revert = 1'b1;
				end else begin
					commit = 1'b1;
					len_push = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			word_cnt <= '0;
			discard <= 1'b0;
			drop_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (take) begin
						state <= GRANTED;
						word_cnt <= '0;
					end else if (wr_en) begin
						state <= DRAIN_END;	// Marker is a packet of one word.
						word_cnt <= pkt_len_t'(1);
						drop_cnt <= '0;
					end
				end
				GRANTED: begin
					if (wr_en)
						word_cnt <= word_cnt + 1'b1;
					if (revert)
						discard <= 1'b1;
					if (sel_end) begin
						discard <= 1'b0;
						if (discard || revert) begin
							drop_cnt <= drop_inc;
							state <= IDLE;
						end else begin
							state <= DRAIN_END;
						end
					end
				end
				DRAIN_END: begin
					if (revert)
						drop_cnt <= drop_inc;	// No room for the length, packet is lost.
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* daq_collector.sv */
`timescale 1ns/1ps

module daq_collector import daq_word_pkg::*, daq_ctrl_pkg::*; #(
	parameter int NSRC = 4,
	parameter int RING_DEPTH = 1024,
	parameter int LEN_BITS = 12,
	parameter int LEN_DEPTH = 64,
	localparam int IDX_BITS = idx_bits(NSRC)
) (
	input logic clk,
	input logic reset,

	// Acquisition sources.
	input logic [NSRC-1:0] src_req,
	input logic [NSRC-1:0] src_valid,
	input logic [NSRC-1:0] src_end,
	input word_t [NSRC-1:0] src_data,
	output logic [NSRC-1:0] src_grant,

	// Word stream.
	output logic out_valid,
	output word_t out_data,
	input logic out_ready,

	// Length stream, one entry per packet.
	output logic len_valid,
	output logic [LEN_BITS-1:0] len_data,
	input logic len_ready
);

	logic pick_valid;
	logic [IDX_BITS-1:0] pick_idx;
	logic take;
	logic sel_valid;
	logic sel_end;
	word_t sel_data;
	logic wr_en;
	word_t wr_data;
	logic commit;
	logic revert;
	logic ring_full;
	logic len_push;
	logic [LEN_BITS-1:0] len_in;
	logic len_full;

	source_select #(.NSRC(NSRC)) u_select (
		.clk(clk), .reset(reset),
		.src_req(src_req), .src_valid(src_valid), .src_end(src_end),
		.src_data(src_data), .src_grant(src_grant),
		.take(take), .pick_valid(pick_valid), .pick_idx(pick_idx),
		.sel_valid(sel_valid), .sel_end(sel_end), .sel_data(sel_data)
	);

	daq_collect_ctrl #(.NSRC(NSRC), .LEN_BITS(LEN_BITS)) u_ctrl (
		.clk(clk), .reset(reset),
		.pick_valid(pick_valid), .pick_idx(pick_idx), .take(take),
		.sel_valid(sel_valid), .sel_end(sel_end), .sel_data(sel_data),
		.wr_en(wr_en), .wr_data(wr_data), .commit(commit), .revert(revert),
		.ring_full(ring_full),
		.len_push(len_push), .len_in(len_in), .len_full(len_full)
	);

	packet_ring #(.RING_DEPTH(RING_DEPTH)) u_ring (
		.clk(clk), .reset(reset),
		.wr_en(wr_en), .wr_data(wr_data), .commit(commit), .revert(revert),
		.ring_full(ring_full),
		.out_valid(out_valid), .out_data(out_data), .out_ready(out_ready)
	);

	len_fifo #(.LEN_BITS(LEN_BITS), .LEN_DEPTH(LEN_DEPTH)) u_len (
		.clk(clk), .reset(reset),
		.len_push(len_push), .len_in(len_in), .len_full(len_full),
		.len_valid(len_valid), .len_data(len_data), .len_ready(len_ready)
	);

endmodule

/* daq_collector_sva.sv */
`timescale 1ns/1ps

module daq_collector_sva import daq_word_pkg::*; #(
	parameter int NSRC = 4,
	parameter int LEN_BITS = 12
) (
	input logic clk,
	input logic reset,
	input logic [NSRC-1:0] src_grant,
	input logic out_valid,
	input word_t out_data,
	input logic out_ready,
	input logic len_valid,
	input logic [LEN_BITS-1:0] len_data,
	input logic len_ready,
	input logic commit
);

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(src_grant))
		else $error("Grant is given to more than one source.");

	grant_pulse: assert property (@(posedge clk) disable iff (reset)
		(src_grant != '0) |=> (src_grant == '0))
		else $error("Grant lasts longer than one cycle.");

	out_hold: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("Word output changed while stalled.");

	len_hold: assert property (@(posedge clk) disable iff (reset)
		(len_valid && !len_ready) |=> (len_valid && $stable(len_data)))
		else $error("Length output changed while stalled.");

	reset_quiet: assert property (@(posedge clk)
		reset |=> (!out_valid && !len_valid && (src_grant == '0)))
		else $error("Outputs are active right after reset.");

	// A committed packet holds at least one word, so the reader must see a word next.
	ring_commit: assert property (@(posedge clk) disable iff (reset) commit |=> out_valid)
		else $error("Committed words do not reach the word output.");

endmodule

bind daq_collector daq_collector_sva #(.NSRC(NSRC), .LEN_BITS(LEN_BITS)) u_sva (
	.clk(clk), .reset(reset), .src_grant(src_grant),
	.out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
	.len_valid(len_valid), .len_data(len_data), .len_ready(len_ready),
	.commit(commit)
);

/* tb_daq_collector.sv */
`timescale 1ns/1ps

module tb_daq_collector import daq_word_pkg::*; ();

	localparam int NSRC = 4;
	localparam int RING_DEPTH = 64;	// Small ring so that back-pressure forces overflow.
	localparam int LEN_BITS = 12;
	localparam int LEN_DEPTH = 64;
	localparam int P1_PKTS = 8;	// Packets per source with both outputs always ready.
	localparam int P3_PKTS = 40;	// Packets per source under random back-pressure.
	localparam int MAX_WORDS = 12;
	// Each word may wait on a slow reader and a source gap, with ample slack.
	localparam int MAX_CYCLES = NSRC * (P1_PKTS + P3_PKTS + 1) * MAX_WORDS * 16;

	logic clk;
	logic reset;
	logic [NSRC-1:0] src_req;
	logic [NSRC-1:0] src_valid;
	logic [NSRC-1:0] src_end;
	word_t [NSRC-1:0] src_data;
	logic [NSRC-1:0] src_grant;
	logic out_valid;
	word_t out_data;
	logic out_ready;
	logic len_valid;
	logic [LEN_BITS-1:0] len_data;
	logic len_ready;

	int errors;
	int cycles;
	int ready_pct;	// Chance in percent that an output accepts in a cycle.
	int sent;
	int delivered;	// Packets rebuilt intact from the two streams.
	int marker_sum;	// Drops reported through marker words.
	int tx_seq [NSRC];
	int rx_seq [NSRC];	// Lowest sequence number still allowed per source.
	int sent_len [NSRC][64];
	int len_q [$];
	word_t word_q [$];

	daq_collector #(.NSRC(NSRC), .RING_DEPTH(RING_DEPTH), .LEN_BITS(LEN_BITS),
		.LEN_DEPTH(LEN_DEPTH)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Source in bits 27:24, packet sequence in 23:12, word index in 11:0.
	function automatic word_t encode_word(input int src, input int seq, input int idx);
		return {4'hA, 4'(src), 12'(seq), 12'(idx)};
	endfunction

	task automatic send_packet(input int src, input int nwords, input int max_gap);
		int seq;
		int k;
		seq = tx_seq[src];
		tx_seq[src]++;
		sent_len[src][seq] = nwords;
		sent++;
		src_req[src] = 1'b1;
		do @(negedge clk); while (!src_grant[src]);
		src_req[src] = 1'b0;	// Grant cycle, the first word comes in the next one.
		for (k = 0; k < nwords; k++) begin
			@(negedge clk);
			src_valid[src] = 1'b0;
			repeat ($urandom_range(max_gap, 0)) @(negedge clk);
			src_valid[src] = 1'b1;
			src_data[src] = encode_word(src, seq, k);
			src_end[src] = (k == nwords - 1);
		end
		@(negedge clk);
		src_valid[src] = 1'b0;
		src_end[src] = 1'b0;
	endtask

	task automatic run_source(input int src, input int npkts, input int max_len);
		repeat (npkts) begin
			repeat ($urandom_range(4, 0)) @(negedge clk);
			send_packet(src, $urandom_range(max_len, 1), 2);
		end
	endtask

	task automatic run_sources(input int npkts, input int max_len);
		fork
			run_source(0, npkts, max_len);
			run_source(1, npkts, max_len);
			run_source(2, npkts, max_len);
			run_source(3, npkts, max_len);
		join
	endtask

	// Splits the word stream by the length stream and checks each packet.
	task automatic rebuild_packets();
		int len;
		int src;
		int seq;
		word_t first;
		while (len_q.size() > 0 && word_q.size() >= len_q[0]) begin
			len = len_q.pop_front();
			first = (len > 0) ? word_q[0] : '0;
			src = int'(first[27:24]);
			seq = int'(first[23:12]);
			if (len == 0) begin
				errors++;
				$display("ERROR: length entry of zero words.");
			end else if (first[31:24] == MARKER_TAG) begin
				compare_value("marker len_data", len, 1);
				marker_sum += int'(first[23:0]);
			end else if (first[31:28] != 4'hA || src >= NSRC || seq >= tx_seq[src]) begin
				errors++;
				$display("ERROR: word %h belongs to no packet that was sent.", first);
			end else begin
				if (seq < rx_seq[src]) begin
					errors++;
					$display("ERROR: source %0d packet %0d came out of order.", src, seq);
				end
				rx_seq[src] = seq + 1;
				compare_value("len_data", len, sent_len[src][seq]);
				for (int k = 0; k < len; k++)
					compare_value("out_data", word_q[k], encode_word(src, seq, k));
				delivered++;
			end
			repeat (len) void'(word_q.pop_front());
		end
	endtask

	// Output side reader with random back-pressure.
	initial begin
		out_ready = 1'b0;
		len_ready = 1'b0;
		forever begin
			@(negedge clk);
			out_ready = ($urandom_range(99, 0) < ready_pct);
			len_ready = ($urandom_range(99, 0) < ready_pct);
			if (out_valid && out_ready)
				word_q.push_back(out_data);
			if (len_valid && len_ready)
				len_q.push_back(int'(len_data));
			rebuild_packets();
		end
	end

	task automatic wait_drained();
		do @(negedge clk);
		while (delivered + marker_sum != sent || word_q.size() != 0 || len_q.size() != 0
			|| out_valid || len_valid);
	endtask

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles before the tests finished.", cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h35b5));
		errors = 0;
		sent = 0;
		delivered = 0;
		marker_sum = 0;
		ready_pct = 100;
		reset = 1'b1;
		src_req = '0;
		src_valid = '0;
		src_end = '0;
		src_data = '0;
		for (int s = 0; s < NSRC; s++) begin
			tx_seq[s] = 0;
			rx_seq[s] = 0;
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		repeat (20) begin	// Idle sources keep every output low.
			@(negedge clk);
			compare_value("out_valid", 32'(out_valid), 0);
			compare_value("len_valid", 32'(len_valid), 0);
			compare_value("src_grant", 32'(src_grant), 0);
		end
		run_sources(P1_PKTS, 4);
		wait_drained();
		compare_value("marker count", marker_sum, 0);
		compare_value("delivered", delivered, sent);
		fork
			send_packet(2, 3, 0);
			send_packet(1, 2, 0);
			begin
				do @(negedge clk); while (src_grant == '0);
				compare_value("src_grant", 32'(src_grant), 32'h2);
			end
		join
		wait_drained();
		ready_pct = 25;
		run_sources(P3_PKTS, MAX_WORDS);
		wait_drained();
		if (marker_sum == 0) begin
			errors++;
			$display("ERROR: back-pressure dropped no packet, overflow was never reached.");
		end
		$display("Errors: %0d, packets sent %0d, delivered %0d, dropped %0d",
			errors, sent, delivered, marker_sum);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* compile.f */
daq_word_pkg.sv
daq_ctrl_pkg.sv
source_select.sv
packet_ring.sv
len_fifo.sv
daq_collect_ctrl.sv
daq_collector.sv
daq_collector_sva.sv
tb_daq_collector.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_daq_collector
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
